// File: gb_io.f
gb_io_pkg.sv
sp_ram.sv
joypad.sv
serial_port.sv
irq_controller.sv
bus_decoder.sv
gb_io.sv
tb_gb_io.sv

// File: Bender.yml
package:
  name: gb_io

sources:
  - gb_io_pkg.sv
  - sp_ram.sv
  - joypad.sv
  - serial_port.sv
  - irq_controller.sv
  - bus_decoder.sv
  - gb_io.sv
  - target: test
    files:
      - tb_gb_io.sv

// File: tb_gb_io.sv
// ------------------------------
// directed testbench for the gb_io bus glue
// drives the cpu bus as a cpu would, checks ram, cartridge port,
// joypad, interrupt controller and serial port responses
// ------------------------------
`default_nettype none

module tb_gb_io;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BIT_CYCLES     = 16;			// serial bit period under test
	localparam int SER_LIMIT      = 9 * BIT_CYCLES + 2;	// worst case transfer
	localparam int TIMEOUT_CYCLES = 4000;			// tests need about 600

	logic        clk_cpu, reset;
	logic [15:0] cpu_addr, cart_addr;
	logic [7:0]  cpu_do, cpu_di, cart_do, cart_di, joystick;
	logic        cpu_rd, cpu_wr, irq_ack, irq;
	logic        vblank_irq, lcdc_irq, timer_irq;
	logic        cart_rd, cart_wr;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [15:0] lfsr = 16'd52;	// seed
	logic [7:0]  wram_model [0:8191];
	logic [7:0]  zp_model [0:127];

	gb_io #(.SERIAL_BIT_CYCLES(BIT_CYCLES)) UUT (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_do     (cpu_do),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.irq_ack    (irq_ack),
		.cpu_di     (cpu_di),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcdc_irq   (lcdc_irq),
		.timer_irq  (timer_irq),
		.joystick   (joystick),
		.cart_do    (cart_do),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_di    (cart_di)
	);

	always #50 clk_cpu = ~clk_cpu;	// 100 ns period

	// ------------------------------
	// helpers
	// ------------------------------
	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	// echo e000-fdff mirrors c000-ddff
	function automatic logic [12:0] fold_wram(input logic [15:0] a);
		if (a >= 16'he000) return 13'(a - 16'he000);
		return 13'(a - 16'hc000);
	endfunction

	task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic wait_cycle();	// edge, then drive point
		@(posedge clk_cpu);
		#10;
	endtask

	task automatic idle(input int n);
		repeat (n) wait_cycle();
	endtask

	task automatic bus_cycle(input logic [15:0] a, input logic rd, input logic wr,
			input logic [7:0] d);
		cpu_addr = a;
		cpu_rd   = rd;
		cpu_wr   = wr;
		cpu_do   = d;
		wait_cycle();	// bus held across one edge
	endtask

	task automatic bus_release();
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		bus_cycle(a, 1'b0, 1'b1, d);
		bus_release();
	endtask

	task automatic cpu_read(input logic [15:0] a, output logic [7:0] d);
		bus_cycle(a, 1'b1, 1'b0, 8'h00);
		d = cpu_di;	// one cycle after address
		bus_release();
	endtask

	task automatic ack_cycle(output logic [7:0] vec);
		irq_ack = 1'b1;
		idle(1);
		vec = cpu_di;
		idle(1);	// ack spans two cycles
		irq_ack = 1'b0;
		idle(1);	// falling edge clears here
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic memory_readback();
		logic [15:0] addrs [$];
		logic [15:0] a, alt;
		logic [12:0] f;
		logic [7:0]  d, got;
		logic [1:0]  kind;
		for (int n = 0; n < 24; n++) begin
			kind = 2'(rand_bits(2));
			if (kind == 2'd0) begin
				a = 16'hc000 + rand_bits(13);
			end else if (kind == 2'd1) begin
				a = 16'he000 + (rand_bits(13) % 16'h1e00);	// echo
			end else begin
				a = 16'hff80 + rand_bits(7);
				if (a == 16'hffff) a = 16'hfffe;	// IE, not ram
			end
			d = 8'(rand_bits(8));
			cpu_write(a, d);
			if (a >= 16'hff80) zp_model[a[6:0]] = d;
			else wram_model[fold_wram(a)] = d;
			addrs.push_back(a);
		end
		foreach (addrs[i]) begin
			a = addrs[i];
			if (a >= 16'hff80) begin
				cpu_read(a, got);
				compare("zero page readback", got, zp_model[a[6:0]]);
			end else begin
				f = fold_wram(a);
				// read through the other alias where one exists
				if (a >= 16'he000) alt = 16'hc000 + f;
				else alt = (f < 13'h1e00) ? 16'he000 + f : a;
				cpu_read(alt, got);
				compare("work ram readback", got, wram_model[f]);
			end
		end
	endtask

	task automatic cart_passthrough();
		logic [15:0] open_addrs [6] = '{16'h8000, 16'h9fff, 16'hfe00, 16'hff01, 16'hff10, 16'hff4d};
		logic [15:0] local_addrs [4] = '{16'hc000, 16'he123, 16'hff85, 16'hff0f};
		logic [15:0] a;
		logic [7:0]  d;
		for (int n = 0; n < 8; n++) begin
			a = n[0] ? 16'ha000 + rand_bits(13) : rand_bits(15);	// ram or rom window
			cart_do = 8'(rand_bits(8));
			bus_cycle(a, 1'b1, 1'b0, 8'h00);
			compare("cart_rd on cart read", cart_rd, 1);
			compare("cart_wr on cart read", cart_wr, 0);
			compare("cart_addr on read", cart_addr, a);
			compare("cart data on cpu_di", cpu_di, cart_do);
			bus_release();
			d = 8'(rand_bits(8));
			bus_cycle(a, 1'b0, 1'b1, d);
			compare("cart_wr on cart write", cart_wr, 1);
			compare("cart_rd on cart write", cart_rd, 0);
			compare("cart_addr on write", cart_addr, a);
			compare("cart_di on write", cart_di, d);
			bus_release();
		end
		foreach (open_addrs[i]) begin
			bus_cycle(open_addrs[i], 1'b1, 1'b0, 8'h00);
			compare("open bus read", cpu_di, 8'hff);
			compare("cart_rd off cart", cart_rd, 0);
			bus_release();
			bus_cycle(open_addrs[i], 1'b0, 1'b1, 8'(rand_bits(8)));
			compare("cart_wr off cart", cart_wr, 0);
			bus_release();
		end
		foreach (local_addrs[i]) begin	// reads only, keeps ram model intact
			bus_cycle(local_addrs[i], 1'b1, 1'b0, 8'h00);
			compare("cart_rd on local read", cart_rd, 0);
			bus_release();
		end
	endtask

	task automatic joypad_lines();
		logic [1:0] sel;
		logic [2:0] b;
		logic [3:0] lines;
		logic [7:0] got;
		int k;
		for (int s = 0; s < 4; s++) begin
			sel = s[1:0];
			cpu_write(16'hff00, {2'b00, sel, 4'h0});
			b = 3'(rand_bits(3));
			joystick = 8'h01 << b;
			lines = 4'hf;	// low = pressed and selected
			if (b < 3'd4 && !sel[0]) lines[b[1:0]] = 1'b0;
			if (b >= 3'd4 && !sel[1]) lines[b[1:0]] = 1'b0;
			cpu_read(16'hff00, got);
			compare("JOYP read", got, {2'b11, sel, lines});
			joystick = 8'h00;
		end
		cpu_write(16'hff00, 8'h00);	// both groups
		idle(3);
		cpu_write(16'hff0f, 8'h00);
		b = 3'(rand_bits(3));
		cpu_addr = 16'hff0f;	// watch IF while pressing
		cpu_rd = 1'b1;
		joystick = 8'h01 << b;
		got = 8'h00;
		for (k = 0; k < 3; k++) begin
			wait_cycle();
			got = cpu_di;
			if (got[4]) break;
		end
		compare("joypad irq flag within 3 cycles", got[4], 1);
		bus_release();
		joystick = 8'h00;
	endtask

	task automatic irq_priority();
		logic [7:0] got;
		cpu_write(16'hffff, 8'h00);
		cpu_write(16'hff0f, 8'h00);
		timer_irq  = 1'b1;
		vblank_irq = 1'b1;
		idle(1);
		timer_irq  = 1'b0;
		vblank_irq = 1'b0;
		cpu_write(16'hffff, 8'h05);	// vblank and timer on
		idle(1);
		compare("irq after enable", irq, 1);
		cpu_read(16'hff0f, got);
		compare("IF with vblank and timer", got, 8'he5);
		ack_cycle(got);
		compare("vblank vector", got, 8'h40);
		cpu_read(16'hff0f, got);
		compare("IF keeps timer only", got, 8'he4);
		ack_cycle(got);
		compare("timer vector", got, 8'h50);
		cpu_read(16'hff0f, got);
		compare("IF empty", got, 8'he0);
		compare("irq low when nothing pending", irq, 0);
		// pending but disabled
		timer_irq = 1'b1;
		idle(1);
		timer_irq = 1'b0;
		cpu_write(16'hffff, 8'h00);
		ack_cycle(got);
		compare("vector with IE cleared", got, 8'h55);
		cpu_read(16'hff0f, got);
		compare("IF untouched by empty ack", got, 8'he4);
	endtask

	task automatic serial_transfer();
		logic [7:0] got;
		logic dropped;
		int k;
		cpu_write(16'hff0f, 8'h00);
		cpu_write(16'hff02, 8'h81);	// start, internal clock
		cpu_addr = 16'hff02;
		cpu_rd = 1'b1;
		got = 8'hff;
		for (k = 0; k < SER_LIMIT; k++) begin
			wait_cycle();
			got = cpu_di;
			if (!got[7]) break;
		end
		bus_release();
		compare("SC after transfer", got, 8'h7f);
		cpu_read(16'hff0f, got);
		compare("serial irq flag", got[3], 1);
		// start without internal clock never finishes
		cpu_write(16'hff0f, 8'h00);
		cpu_write(16'hff02, 8'h80);
		cpu_addr = 16'hff02;
		cpu_rd = 1'b1;
		dropped = 1'b0;
		for (k = 0; k < SER_LIMIT; k++) begin
			wait_cycle();
			if (!cpu_di[7]) dropped = 1'b1;
		end
		bus_release();
		compare("SC bit 7 held, external clock", dropped, 0);
		cpu_read(16'hff02, got);
		compare("SC read, external clock", got, 8'hfe);
		cpu_read(16'hff0f, got);
		compare("no serial irq", got[3], 0);
	endtask

	// ------------------------------
	// run control
	// ------------------------------
	always @(posedge clk_cpu) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		clk_cpu    = 1'b0;
		reset      = 1'b1;
		cpu_addr   = 16'h0000;
		cpu_do     = 8'h00;
		cpu_rd     = 1'b0;
		cpu_wr     = 1'b0;
		irq_ack    = 1'b0;
		vblank_irq = 1'b0;
		lcdc_irq   = 1'b0;
		timer_irq  = 1'b0;
		joystick   = 8'h00;	// nothing pressed
		cart_do    = 8'h00;
		repeat (10) @(posedge clk_cpu);
		#10 reset = 1'b0;
		memory_readback();
		cart_passthrough();
		joypad_lines();
		irq_priority();
		serial_transfer();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) $display("Finished with no errors");
		else $display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: gb_io.sv
// ------------------------------
// gb_io top, system bus glue of the console
// cpu bus in, cartridge port out, local rams and io inside
// ------------------------------
`default_nettype none

module gb_io #(
	parameter int SERIAL_BIT_CYCLES = gb_io_pkg::SERIAL_BIT_CYCLES_DEF
) (
	input  logic              clk_cpu,
	input  logic              reset,
	// cpu bus
	input  gb_io_pkg::addr_t  cpu_addr,
	input  gb_io_pkg::byte_t  cpu_do,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  logic              irq_ack,
	output gb_io_pkg::byte_t  cpu_di,
	output logic              irq,
	// irq strobes of video and timer
	input  logic              vblank_irq,
	input  logic              lcdc_irq,
	input  logic              timer_irq,
	input  logic [7:0]        joystick,
	// cartridge
	input  gb_io_pkg::byte_t  cart_do,
	output gb_io_pkg::addr_t  cart_addr,
	output logic              cart_rd,
	output logic              cart_wr,
	output gb_io_pkg::byte_t  cart_di
);
	import gb_io_pkg::*;

	byte_t irq_vector, if_do, ie_do, joyp_do, sc_do;
	byte_t wram_do, zpram_do;
	logic [WRAM_AW-1:0] wram_addr;
	logic wram_we, zpram_we, joyp_we, sc_we, if_we, ie_we;
	logic joy_irq, serial_irq;
	irq_vec_t irq_src;

	// ------------------------------
	// interrupt sources
	// ------------------------------
	assign irq_src[IRQ_VBLANK] = vblank_irq;
	assign irq_src[IRQ_LCDC]   = lcdc_irq;
	assign irq_src[IRQ_TIMER]  = timer_irq;
	assign irq_src[IRQ_SERIAL] = serial_irq;
	assign irq_src[IRQ_JOYPAD] = joy_irq;

	bus_decoder u_bus_decoder (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_do     (cpu_do),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.irq_ack    (irq_ack),
		.irq_vector (irq_vector),
		.if_do      (if_do),
		.ie_do      (ie_do),
		.joyp_do    (joyp_do),
		.sc_do      (sc_do),
		.wram_do    (wram_do),
		.zpram_do   (zpram_do),
		.cart_do    (cart_do),
		.cpu_di     (cpu_di),
		.wram_addr  (wram_addr),
		.wram_we    (wram_we),
		.zpram_we   (zpram_we),
		.joyp_we    (joyp_we),
		.sc_we      (sc_we),
		.if_we      (if_we),
		.ie_we      (ie_we),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_di    (cart_di)
	);

	irq_controller u_irq_controller (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.irq_ack    (irq_ack),
		.if_we      (if_we),
		.ie_we      (ie_we),
		.cpu_do     (cpu_do),
		.irq_src    (irq_src),
		.irq        (irq),
		.irq_vector (irq_vector),
		.if_do      (if_do),
		.ie_do      (ie_do)
	);

	joypad u_joypad (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.joyp_we  (joyp_we),
		.cpu_do   (cpu_do),
		.joystick (joystick),
		.joyp_do  (joyp_do),
		.joy_irq  (joy_irq)
	);

	serial_port #(.SERIAL_BIT_CYCLES(SERIAL_BIT_CYCLES)) u_serial_port (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.sc_we      (sc_we),
		.cpu_do     (cpu_do),
		.sc_do      (sc_do),
		.serial_irq (serial_irq)
	);

	// ------------------------------
	// rams
	// ------------------------------
	sp_ram #(.AW(WRAM_AW), .DW(8)) wram (	// c000-dfff plus echo
		.clk_cpu (clk_cpu),
		.addr    (wram_addr),
		.we      (wram_we),
		.wdata   (cpu_do),
		.rdata   (wram_do)
	);

	sp_ram #(.AW(ZPRAM_AW), .DW(8)) zpram (	// ff80-fffe
		.clk_cpu (clk_cpu),
		.addr    (cpu_addr[ZPRAM_AW-1:0]),
		.we      (zpram_we),
		.wdata   (cpu_do),
		.rdata   (zpram_do)
	);

endmodule

`default_nettype wire

// File: bus_decoder.sv
// ------------------------------
// cpu bus decode, write strobes and read data mux
// also drives the cartridge port
// ------------------------------
`default_nettype none

module bus_decoder (
	input  logic                              clk_cpu,
	input  logic                              reset,
	input  gb_io_pkg::addr_t                  cpu_addr,
	input  gb_io_pkg::byte_t                  cpu_do,
	input  logic                              cpu_rd,
	input  logic                              cpu_wr,
	input  logic                              irq_ack,
	input  gb_io_pkg::byte_t                  irq_vector,
	input  gb_io_pkg::byte_t                  if_do,
	input  gb_io_pkg::byte_t                  ie_do,
	input  gb_io_pkg::byte_t                  joyp_do,
	input  gb_io_pkg::byte_t                  sc_do,
	input  gb_io_pkg::byte_t                  wram_do,
	input  gb_io_pkg::byte_t                  zpram_do,
	input  gb_io_pkg::byte_t                  cart_do,
	output gb_io_pkg::byte_t                  cpu_di,
	output logic [gb_io_pkg::WRAM_AW-1:0]     wram_addr,
	output logic                              wram_we,
	output logic                              zpram_we,
	output logic                              joyp_we,
	output logic                              sc_we,
	output logic                              if_we,
	output logic                              ie_we,
	output gb_io_pkg::addr_t                  cart_addr,
	output logic                              cart_rd,
	output logic                              cart_wr,
	output gb_io_pkg::byte_t                  cart_di
);
	import gb_io_pkg::*;

	bus_region_t region;
	bus_region_t region_q;	// region of last cycle, for ram data
	logic        sel_cart;

	// ------------------------------
	// address decode
	// ------------------------------
	always_comb begin
		if (!cpu_addr[15])                            region = REG_CART_ROM;	// 0000-7fff
		else if (cpu_addr[15:13] == 3'b101)           region = REG_CART_RAM;	// a000-bfff
		else if (cpu_addr[15:13] == 3'b110)           region = REG_WRAM;	// c000-dfff
		else if (cpu_addr[15:13] == 3'b111 && cpu_addr < 16'hfe00)
			region = REG_WRAM;	// echo
		else if (cpu_addr == ADDR_IE)                 region = REG_IE;
		else if (&cpu_addr[15:ZPRAM_AW])              region = REG_ZPRAM;	// ff80-fffe
		else if (cpu_addr == ADDR_JOYP)               region = REG_JOYP;
		else if (cpu_addr == ADDR_SB)                 region = REG_SB;
		else if (cpu_addr == ADDR_SC)                 region = REG_SC;
		else if (cpu_addr == ADDR_IF)                 region = REG_IF;
		else                                          region = REG_NONE;	// vram, oam, rest of io
	end

	// echo e000-fdff lands on c000-ddff by dropping the top bits
	assign wram_addr = cpu_addr[WRAM_AW-1:0];

	assign wram_we  = cpu_wr && (region == REG_WRAM);
	assign zpram_we = cpu_wr && (region == REG_ZPRAM);
	assign joyp_we  = cpu_wr && (region == REG_JOYP);
	assign sc_we    = cpu_wr && (region == REG_SC);
	assign if_we    = cpu_wr && (region == REG_IF);
	assign ie_we    = cpu_wr && (region == REG_IE);

	// ------------------------------
	// cartridge port
	// ------------------------------
	assign sel_cart  = (region == REG_CART_ROM) || (region == REG_CART_RAM);
	assign cart_addr = cpu_addr;
	assign cart_rd   = cpu_rd && sel_cart;
	assign cart_wr   = cpu_wr && sel_cart;
	assign cart_di   = cpu_do;

	always_ff @(posedge clk_cpu) begin
		if (reset) region_q <= REG_NONE;
		else region_q <= region;	// ram read data lags one cycle
	end

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		if (irq_ack) begin
			cpu_di = irq_vector;	// vector fetch
		end else begin
			case (region)
				REG_CART_ROM, REG_CART_RAM: cpu_di = cart_do;
				REG_WRAM:  cpu_di = (region_q == REG_WRAM) ? wram_do : OPEN_BUS;
				REG_ZPRAM: cpu_di = (region_q == REG_ZPRAM) ? zpram_do : OPEN_BUS;
				REG_JOYP:  cpu_di = joyp_do;
				REG_SC:    cpu_di = sc_do;
				REG_IF:    cpu_di = if_do;
				REG_IE:    cpu_di = ie_do;
				default:   cpu_di = OPEN_BUS;	// SB and unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

// File: irq_controller.sv
// ------------------------------
// interrupt controller, IF at ff0f and IE at ffff
// drives irq level and the vector for the ack cycle
// ------------------------------
`default_nettype none

module irq_controller (
	input  logic                 clk_cpu,
	input  logic                 reset,
	input  logic                 irq_ack,
	input  logic                 if_we,
	input  logic                 ie_we,
	input  gb_io_pkg::byte_t     cpu_do,
	input  gb_io_pkg::irq_vec_t  irq_src,	// one cycle strobes
	output logic                 irq,
	output gb_io_pkg::byte_t     irq_vector,
	output gb_io_pkg::byte_t     if_do,
	output gb_io_pkg::byte_t     ie_do
);
	import gb_io_pkg::*;

	irq_vec_t if_r, ie_r;
	irq_vec_t pending;		// flagged and enabled
	irq_vec_t clr_mask;		// one-hot, winner of priority
	logic [2:0] sel;		// winner index
	logic found;
	logic ack_q;
	logic ack_fall;

	assign pending  = if_r & ie_r;
	assign ack_fall = ack_q & ~irq_ack;	// ack cycle over

	// ------------------------------
	// priority encoder, lowest bit wins
	// ------------------------------
	always_comb begin
		sel   = '0;
		found = 1'b0;
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
			if (pending[i]) begin
				sel   = 3'(i);
				found = 1'b1;
			end
		end
		clr_mask = found ? irq_vec_t'(1) << sel : '0;
	end

	assign irq_vector = found ? IRQ_VEC_BASE + byte_t'({sel, 3'b000}) : IRQ_VEC_NONE;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r  <= '0;
			ie_r  <= '0;
			ack_q <= 1'b0;
			irq   <= 1'b0;
		end else begin
			ack_q <= irq_ack;
			irq   <= |pending;
			// sources set, ack clears the serviced one
			if_r  <= (if_r | irq_src) & ~(ack_fall ? clr_mask : irq_vec_t'(0));
			if (if_we) if_r <= cpu_do[IRQ_COUNT-1:0];	// cpu write wins
			if (ie_we) ie_r <= cpu_do[IRQ_COUNT-1:0];
		end
	end

	// unused upper bits: IF reads 1, IE reads 0
	assign if_do = {{(8 - IRQ_COUNT){1'b1}}, if_r};
	assign ie_do = {{(8 - IRQ_COUNT){1'b0}}, ie_r};

endmodule

`default_nettype wire

// File: serial_port.sv
// ------------------------------
// dummy serial port, SC register at ff02
// no data moves, a started transfer just times out
// ------------------------------
`default_nettype none

module serial_port #(
	parameter int SERIAL_BIT_CYCLES = gb_io_pkg::SERIAL_BIT_CYCLES_DEF
) (
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic              sc_we,
	input  gb_io_pkg::byte_t  cpu_do,
	output gb_io_pkg::byte_t  sc_do,
	output logic              serial_irq
);
	import gb_io_pkg::*;

	localparam int DIV_W = (SERIAL_BIT_CYCLES > 1) ? $clog2(SERIAL_BIT_CYCLES) : 1;
	localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(SERIAL_BIT_CYCLES - 1);

	serial_state_t   state;
	logic            sc_start;		// bit 7, transfer busy
	logic            sc_clk;		// bit 0, internal clock
	logic [DIV_W-1:0] clk_div;		// cycles left in bit
	logic [2:0]      bit_cnt;		// bits done

	always_ff @(posedge clk_cpu) begin
		serial_irq <= 1'b0;	// single cycle pulse
		if (reset) begin
			state    <= SER_IDLE;
			sc_start <= 1'b0;
			sc_clk   <= 1'b0;
			clk_div  <= '0;
			bit_cnt  <= '0;
		end else if (sc_we) begin
			sc_start <= cpu_do[7];
			sc_clk   <= cpu_do[0];
			clk_div  <= DIV_LOAD;
			bit_cnt  <= '0;
			// only internal clock moves bits, external never arrives
			state    <= (cpu_do[7] && cpu_do[0]) ? SER_SHIFT : SER_IDLE;
		end else if (state == SER_SHIFT) begin
			if (clk_div != '0) begin
				clk_div <= clk_div - 1'b1;
			end else begin
				clk_div <= DIV_LOAD;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7) begin	// eighth bit out
					state      <= SER_IDLE;
					sc_start   <= 1'b0;
					serial_irq <= 1'b1;
				end
			end
		end
	end

	assign sc_do = {sc_start, 6'b111111, sc_clk};

endmodule

`default_nettype wire

// File: joypad.sv
// ------------------------------
// JOYP register at ff00
// merges the two key groups and flags new presses
// ------------------------------
`default_nettype none

module joypad (
	input  logic              clk_cpu,
	input  logic              reset,
	input  logic              joyp_we,
	input  gb_io_pkg::byte_t  cpu_do,
	input  logic [7:0]        joystick,	// high = pressed
	output gb_io_pkg::byte_t  joyp_do,
	output logic              joy_irq
);
	import gb_io_pkg::*;

	logic [1:0] p54;		// group select, 0 = selected
	logic [3:0] dir_lines;		// right left up down
	logic [3:0] btn_lines;		// a b select start
	logic [7:0] lines_d1, lines_d2;

	always_ff @(posedge clk_cpu) begin
		if (reset) p54 <= 2'b00;	// both groups on
		else if (joyp_we) p54 <= cpu_do[5:4];
	end

	// a deselected group floats high
	assign dir_lines = ~joystick[3:0] | {4{p54[0]}};
	assign btn_lines = ~joystick[7:4] | {4{p54[1]}};

	assign joyp_do = {2'b11, p54, dir_lines & btn_lines};

	// ------------------------------
	// falling edge on any line
	// ------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			lines_d1 <= '1;	// released
			lines_d2 <= '1;
		end else begin
			lines_d1 <= {dir_lines, btn_lines};
			lines_d2 <= lines_d1;
		end
	end

	assign joy_irq = |(~lines_d1 & lines_d2);

endmodule

`default_nettype wire

// File: sp_ram.sv
// ------------------------------
// single port ram, registered read
// one word of latency, no reset
// ------------------------------
`default_nettype none

module sp_ram #(
	parameter int AW = 8,
	parameter int DW = 8
) (
	input  logic          clk_cpu,
	input  logic [AW-1:0] addr,
	input  logic          we,
	input  logic [DW-1:0] wdata,
	output logic [DW-1:0] rdata
);

	logic [DW-1:0] mem [2**AW];

	always_ff @(posedge clk_cpu) begin
		if (we) mem[addr] <= wdata;
		rdata <= mem[addr];	// read before write on same address
	end

endmodule

`default_nettype wire

// File: gb_io_pkg.sv
// ------------------------------
// shared types and constants of the gb_io bus glue
// imported by every module except the RAM
// ------------------------------
`default_nettype none

package gb_io_pkg;

	// ------------------------------
	// bus types
	// ------------------------------
	typedef logic [15:0] addr_t;	// cpu address
	typedef logic [7:0]  byte_t;	// cpu data

	localparam int IRQ_COUNT = 5;	// vblank, lcdc, timer, serial, joypad
	typedef logic [IRQ_COUNT-1:0] irq_vec_t;

	// interrupt bit positions, 0 wins
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCDC   = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	// ------------------------------
	// memory map
	// ------------------------------
	localparam addr_t ADDR_JOYP = 16'hff00;
	localparam addr_t ADDR_SB   = 16'hff01;	// serial data, dummy
	localparam addr_t ADDR_SC   = 16'hff02;	// serial control
	localparam addr_t ADDR_IF   = 16'hff0f;
	localparam addr_t ADDR_IE   = 16'hffff;

	localparam int WRAM_AW  = 13;	// 8k work ram
	localparam int ZPRAM_AW = 7;	// zero page, 127 used

	localparam byte_t IRQ_VEC_BASE = 8'h40;	// rst vector of source 0, +8 per source
	localparam byte_t IRQ_VEC_NONE = 8'h55;	// ack with nothing pending
	localparam byte_t OPEN_BUS     = 8'hff;

	localparam int SERIAL_BIT_CYCLES_DEF = 512;	// ~8 kHz bit clock at 4 MHz

	// decoded bus target
	typedef enum logic [3:0] {
		REG_NONE, REG_CART_ROM, REG_CART_RAM, REG_WRAM, REG_ZPRAM,
		REG_JOYP, REG_SB, REG_SC, REG_IF, REG_IE
	} bus_region_t;

	typedef enum logic {SER_IDLE, SER_SHIFT} serial_state_t;

endpackage

`default_nettype wire
